/* Bender.yml */
package:
  name: fp_alu

sources:
  - common/fpPkg.sv
  - fpAddSub/fpAlign.sv
  - fpAddSub/fpNormalize.sv
  - hdl/fpWbRegs.sv
  - hdl/fpAluTop.sv
  - target: test
    files:
      - tb/fpClockGen.sv
      - tb/fpAlu_assert.sv
      - tb/fpAluTb.sv

/* common/fpPkg.sv */
package fpPkg;

	//////////////////////////////////////////////////////////////////////
	// binary32 field layout
	//////////////////////////////////////////////////////////////////////

	localparam int expWidth = 8;               // biased exponent field
	localparam int manWidth = 23;              // stored fraction bits
	localparam int bias     = 127;             // exponent bias

	// aligned sum: carry, hidden bit, then the fraction
	localparam int sigWidth = manWidth + 2;

	//////////////////////////////////////////////////////////////////////
	// opcodes and bus map
	//////////////////////////////////////////////////////////////////////

	typedef enum logic {
		opAdd = 1'b0,
		opSub = 1'b1
	} fpOp;

	typedef enum logic [2:0] {
		addrOpA    = 3'd0,                      // operand A
		addrOpB    = 3'd1,                      // operand B
		addrCtrl   = 3'd2,                      // opcode, write starts
		addrResult = 3'd3,                      // packed result, read clears done
		addrStatus = 3'd4                       // flags, done, busy
	} regAddr;

	//////////////////////////////////////////////////////////////////////
	// flag and status bit positions
	//////////////////////////////////////////////////////////////////////

	localparam int flagZero      = 0;
	localparam int flagOverflow  = 1;
	localparam int flagUnderflow = 2;

	// status word keeps the flags in its low bits
	localparam int statusDone = 3;
	localparam int statusBusy = 4;

endpackage

/* fpAddSub/fpAlign.sv */
`timescale 1ns/1ps

module fpAlign (
	input  logic                         clk,
	input  logic                         rstN,
	input  logic                         start,
	input  logic [31:0]                  opA,
	input  logic [31:0]                  opB,
	input  fpPkg::fpOp                   op,
	output logic                         alignValid,
	output logic                         sign,
	output logic [fpPkg::expWidth-1:0]   expLarge,
	output logic [fpPkg::sigWidth-1:0]   magnitude
);
	import fpPkg::*;

	logic                signA;
	logic                signB;
	logic [expWidth-1:0] expA;
	logic [expWidth-1:0] expB;
	logic [manWidth:0]   sigA;
	logic [manWidth:0]   sigB;
	logic                swap;
	logic                signL;
	logic                effSub;
	logic [expWidth-1:0] expL;
	logic [expWidth-1:0] expS;
	logic [expWidth-1:0] expDiff;
	logic [manWidth:0]   sigL;
	logic [manWidth:0]   sigS;
	logic [manWidth:0]   sigShift;
	logic [sigWidth-1:0] sum;

	//////////////////////////////////////////////////////////////////////
	// unpack
	//////////////////////////////////////////////////////////////////////

	assign signA = opA[31];
	assign signB = opB[31] ^ (op == opSub);           // subtract flips B
	assign expA  = opA[manWidth +: expWidth];
	assign expB  = opB[manWidth +: expWidth];

	// exponent field 0 reads as zero, fraction ignored
	assign sigA = (expA == '0) ? '0 : {1'b1, opA[manWidth-1:0]};
	assign sigB = (expB == '0) ? '0 : {1'b1, opB[manWidth-1:0]};

	//////////////////////////////////////////////////////////////////////
	// order by magnitude and align
	//////////////////////////////////////////////////////////////////////

	assign swap  = {expB, sigB} > {expA, sigA};       // B strictly larger
	assign signL = swap ? signB : signA;
	assign expL  = swap ? expB : expA;
	assign expS  = swap ? expA : expB;
	assign sigL  = swap ? sigB : sigA;
	assign sigS  = swap ? sigA : sigB;

	assign expDiff = expL - expS;                     // never negative

	// gap past the hidden bit shifts everything out
	assign sigShift = (expDiff > manWidth) ? '0 : (sigS >> expDiff);

	//////////////////////////////////////////////////////////////////////
	// add or subtract magnitudes
	//////////////////////////////////////////////////////////////////////

	assign effSub = signA ^ signB;

	// larger minus smaller stays non-negative
	assign sum = effSub ? ({1'b0, sigL} - {1'b0, sigShift})
	                    : ({1'b0, sigL} + {1'b0, sigShift});

	always_ff @(posedge clk) begin
		if (!rstN) begin
			alignValid <= 1'b0;
		end else begin
			alignValid <= start;                      // one stage of latency
		end
	end

	always_ff @(posedge clk) begin
		sign      <= signL;                           // result takes larger sign
		expLarge  <= expL;
		magnitude <= sum;
	end

endmodule

/* fpAddSub/fpNormalize.sv */
`timescale 1ns/1ps

module fpNormalize (
	input  logic                         clk,
	input  logic                         rstN,
	input  logic                         alignValid,
	input  logic                         sign,
	input  logic [fpPkg::expWidth-1:0]   expLarge,
	input  logic [fpPkg::sigWidth-1:0]   magnitude,
	output logic                         resValid,
	output logic [31:0]                  result,
	output logic [2:0]                   flags
);
	import fpPkg::*;

	logic                       carry;
	logic [4:0]                 shift;
	logic [manWidth:0]          normSig;
	logic signed [expWidth+1:0] expAdj;
	logic [31:0]                packWord;
	logic [2:0]                 packFlags;

	//////////////////////////////////////////////////////////////////////
	// leading-one priority encoder
	//////////////////////////////////////////////////////////////////////

	assign carry = magnitude[sigWidth-1];

	// highest set bit below the carry wins
	always_comb begin
		shift = 5'd0;
		for (int i = 0; i <= manWidth; i++) begin
			if (magnitude[i]) begin
				shift = 5'(manWidth - i);
			end
		end
	end

	// carry needs one step right, otherwise shift left to the hidden bit
	assign normSig = carry ? magnitude[sigWidth-1:1]
	                       : (magnitude[manWidth:0] << shift);

	// two extra bits keep the sign and the overflow range
	assign expAdj = carry ? ($signed({2'b00, expLarge}) + 10'sd1)
	                      : ($signed({2'b00, expLarge}) - $signed({5'b00000, shift}));

	//////////////////////////////////////////////////////////////////////
	// pack with flags
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		packFlags = '0;
		if (magnitude == '0) begin
			packWord = '0;                            // exact zero is positive
			packFlags[flagZero] = 1'b1;
		end else if (expAdj <= 0) begin
			packWord = {sign, 31'b0};                 // flush, keep sign
			packFlags[flagUnderflow] = 1'b1;
		end else if (expAdj >= 2 * bias + 1) begin
			packWord = {sign, {expWidth{1'b1}}, {manWidth{1'b0}}};  // infinity
			packFlags[flagOverflow] = 1'b1;
		end else begin
			packWord = {sign, expAdj[expWidth-1:0], normSig[manWidth-1:0]};
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			resValid <= 1'b0;
		end else begin
			resValid <= alignValid;
		end
	end

	always_ff @(posedge clk) begin
		result <= packWord;                           // hidden bit dropped
		flags  <= packFlags;
	end

endmodule

/* hdl/fpAluTop.sv */
`timescale 1ns/1ps

module fpAluTop (
	input  logic          clk,
	input  logic          rstN,
	input  logic          wbCyc,
	input  logic          wbStb,
	input  logic          wbWe,
	input  fpPkg::regAddr wbAdr,
	input  logic [31:0]   wbDatW,
	output logic [31:0]   wbDatR,
	output logic          wbAck
);
	import fpPkg::*;

	logic [31:0]         opA;
	logic [31:0]         opB;
	fpOp                 op;
	logic                start;
	logic                alignValid;
	logic                sign;
	logic [expWidth-1:0] expLarge;
	logic [sigWidth-1:0] magnitude;
	logic                resValid;
	logic [31:0]         result;
	logic [2:0]          flags;

	//////////////////////////////////////////////////////////////////////
	// bus registers, then align/add, then normalize
	//////////////////////////////////////////////////////////////////////

	fpWbRegs uRegs (
		.clk(clk), .rstN(rstN),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
		.wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck),
		.opA(opA), .opB(opB), .op(op), .start(start),
		.resValid(resValid), .result(result), .flags(flags)
	);

	fpAlign uAlign (
		.clk(clk), .rstN(rstN), .start(start),
		.opA(opA), .opB(opB), .op(op),
		.alignValid(alignValid), .sign(sign),
		.expLarge(expLarge), .magnitude(magnitude)
	);

	fpNormalize uNorm (
		.clk(clk), .rstN(rstN), .alignValid(alignValid),
		.sign(sign), .expLarge(expLarge), .magnitude(magnitude),
		.resValid(resValid), .result(result), .flags(flags)
	);

endmodule

/* hdl/fpWbRegs.sv */
`timescale 1ns/1ps

module fpWbRegs (
	input  logic          clk,
	input  logic          rstN,
	input  logic          wbCyc,
	input  logic          wbStb,
	input  logic          wbWe,
	input  fpPkg::regAddr wbAdr,
	input  logic [31:0]   wbDatW,
	output logic [31:0]   wbDatR,
	output logic          wbAck,
	output logic [31:0]   opA,
	output logic [31:0]   opB,
	output fpPkg::fpOp    op,
	output logic          start,
	input  logic          resValid,
	input  logic [31:0]   result,
	input  logic [2:0]    flags
);
	import fpPkg::*;

	logic [31:0] regA;
	logic [31:0] regB;
	logic [31:0] resultReg;
	logic [2:0]  flagsReg;
	logic        done;
	logic        busy;
	logic        access;
	logic        busWrite;
	logic        launch;
	logic        resultRead;
	logic [31:0] statusWord;
	logic [31:0] readData;

	//////////////////////////////////////////////////////////////////////
	// bus decode
	//////////////////////////////////////////////////////////////////////

	assign access     = wbCyc && wbStb && !wbAck;     // ack goes out on this edge
	assign busWrite   = access && wbWe && !busy;      // busy writes are dropped
	assign launch     = busWrite && (wbAdr == addrCtrl);
	assign resultRead = access && !wbWe && (wbAdr == addrResult);

	always_comb begin
		statusWord = '0;
		statusWord[flagUnderflow:flagZero] = flagsReg;
		statusWord[statusDone] = done;
		statusWord[statusBusy] = busy;
	end

	always_comb begin
		case (wbAdr)
			addrOpA:    readData = regA;
			addrOpB:    readData = regB;
			addrCtrl:   readData = {31'b0, op};       // last launched opcode
			addrResult: readData = resultReg;
			addrStatus: readData = statusWord;
			default:    readData = '0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// ack, operand registers and launch
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rstN) begin
			wbAck  <= 1'b0;
			wbDatR <= '0;
			regA   <= '0;
			regB   <= '0;
			opA    <= '0;
			opB    <= '0;
			op     <= opAdd;
			start  <= 1'b0;
		end else begin
			wbAck <= access;                          // single-cycle ack
			start <= launch;
			if (access && !wbWe) begin
				wbDatR <= readData;
			end
			if (busWrite && (wbAdr == addrOpA)) begin
				regA <= wbDatW;
			end
			if (busWrite && (wbAdr == addrOpB)) begin
				regB <= wbDatW;
			end
			if (launch) begin
				opA <= regA;                          // snapshot for the stages
				opB <= regB;
				op  <= fpOp'(wbDatW[0]);
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// busy and done tracking
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rstN) begin
			resultReg <= '0;
			flagsReg  <= '0;
			done      <= 1'b0;
			busy      <= 1'b0;
		end else begin
			if (resValid) begin
				resultReg <= result;
				flagsReg  <= flags;
				done      <= 1'b1;
				busy      <= 1'b0;
			end else if (launch) begin
				busy <= 1'b1;
				done <= 1'b0;                         // old result is stale now
			end else if (resultRead) begin
				done <= 1'b0;
			end
		end
	end

endmodule

/* src.f */
common/fpPkg.sv
fpAddSub/fpAlign.sv
fpAddSub/fpNormalize.sv
hdl/fpWbRegs.sv
hdl/fpAluTop.sv
tb/fpClockGen.sv
tb/fpAlu_assert.sv
tb/fpAluTb.sv

/* tb/fpAluTb.sv */
`timescale 1ns/1ps

module fpAluTb;
	import fpPkg::*;

	localparam int ackLimit    = 8;                   // cycles to wait for wbAck
	localparam int pollLimit   = 20;
	localparam int nsPerVector = 200;
	localparam int resetNs     = 50;                  // 5 cycles of 10 ns

	logic        clk;
	logic        rstN;
	logic        wbCyc;
	logic        wbStb;
	logic        wbWe;
	regAddr      wbAdr;
	logic [31:0] wbDatW;
	logic [31:0] wbDatR;
	logic        wbAck;

	fpOp         vecOp[$];
	logic [31:0] vecA[$];
	logic [31:0] vecB[$];
	logic [31:0] vecRes[$];
	logic [2:0]  vecFlags[$];

	int   errorCount    = 0;
	int   testCount     = 0;
	int   passCount     = 0;
	int   failCount     = 0;
	logic vectorsLoaded = 1'b0;

	fpClockGen uClk (.clk(clk), .rstN(rstN));

	fpAluTop UUT (
		.clk(clk), .rstN(rstN),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
		.wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck)
	);

	bind fpAluTop fpAluAssert uAssert (
		.clk(clk), .rstN(rstN), .wbAck(wbAck), .start(start),
		.resValid(resValid), .busy(uRegs.busy), .done(uRegs.done)
	);

	//////////////////////////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic checkResult(input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: result expected %h got %h", $time, exp, got);
			errorCount++;
		end
	endtask

	task automatic checkFlags(input logic [2:0] got, input logic [2:0] exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: flags expected %b got %b", $time, exp, got);
			errorCount++;
		end
	endtask

	task automatic checkReg(input regAddr addr, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s expected %h got %h", $time, addr.name(), exp, got);
			errorCount++;
		end
	endtask

	// flags low, then done and busy above them
	function automatic logic [31:0] expectStatus(input logic [2:0] flg, input logic dn,
	                                             input logic bsy);
		return (32'(bsy) << statusBusy) | (32'(dn) << statusDone) | 32'(flg);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Wishbone master, called 1 ns after a rising edge
	//////////////////////////////////////////////////////////////////////

	task automatic busAccess(input regAddr addr, input logic we, input logic [31:0] wdata,
	                         output logic [31:0] rdata);
		int waitCycles;
		waitCycles = 0;
		wbCyc  = 1'b1;
		wbStb  = 1'b1;
		wbWe   = we;
		wbAdr  = addr;
		wbDatW = wdata;
		do begin
			@(posedge clk);
			#1 waitCycles++;
		end while (!wbAck && waitCycles < ackLimit);
		if (!wbAck) begin
			$display("bus access to %s got no acknowledge in %0d cycles", addr.name(), ackLimit);
			errorCount++;
		end
		rdata = wbDatR;                               // valid while ack is high
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe  = 1'b0;
		@(posedge clk);
		#1;
	endtask

	task automatic writeReg(input regAddr addr, input logic [31:0] data);
		logic [31:0] unused;
		busAccess(addr, 1'b1, data, unused);
	endtask

	task automatic readReg(input regAddr addr, output logic [31:0] data);
		busAccess(addr, 1'b0, '0, data);
	endtask

	task automatic waitDone(output logic seen);
		logic [31:0] status;
		int          polls;
		seen  = 1'b0;
		polls = 0;
		while (!seen && polls < pollLimit) begin
			readReg(addrStatus, status);
			polls++;
			seen = status[statusDone];
		end
		if (!seen) begin
			$display("operation hung, done never set after %0d status polls", pollLimit);
			errorCount++;
		end
	endtask

	task automatic finishTest(input string name, input int errorsBefore);
		testCount++;
		if (errorCount == errorsBefore) begin
			passCount++;
			$display("test %0d %s: ok", testCount, name);
		end else begin
			failCount++;
			$display("test %0d %s: fail", testCount, name);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// tests
	//////////////////////////////////////////////////////////////////////

	task automatic loadVectors();
		int          fd;
		int          fields;
		string       line;
		logic [31:0] opWord;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic [31:0] flg;
		fd = $fopen("tb/fpTestdata.txt", "r");
		if (fd == 0) begin
			$display("cannot open test data file tb/fpTestdata.txt");
			errorCount++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			fields = $sscanf(line, "%h %h %h %h %h", opWord, a, b, res, flg);
			if (fields == 5) begin                    // comment and blank lines skipped
				vecOp.push_back(fpOp'(opWord[0]));
				vecA.push_back(a);
				vecB.push_back(b);
				vecRes.push_back(res);
				vecFlags.push_back(flg[2:0]);
			end
		end
		$fclose(fd);
		if (vecA.size() == 0) begin
			$display("test data file holds no vectors");
			errorCount++;
		end else begin
			vectorsLoaded = 1'b1;
		end
	endtask

	task automatic testReadback();
		int          errorsBefore;
		logic [31:0] data;
		errorsBefore = errorCount;
		readReg(addrStatus, data);
		checkReg(addrStatus, data, 32'h0);            // idle after reset
		writeReg(addrOpA, 32'h1234_5678);
		writeReg(addrOpB, 32'hdead_beef);
		readReg(addrOpA, data);
		checkReg(addrOpA, data, 32'h1234_5678);
		readReg(addrOpB, data);
		checkReg(addrOpB, data, 32'hdead_beef);
		finishTest("operand readback", errorsBefore);
	endtask

	task automatic runVector(input int idx);
		int          errorsBefore;
		logic [31:0] data;
		logic        seen;
		logic [2:0]  prevFlags;
		errorsBefore = errorCount;
		prevFlags    = (idx == 0) ? 3'b000 : vecFlags[idx-1];
		writeReg(addrOpA, vecA[idx]);
		writeReg(addrOpB, vecB[idx]);
		writeReg(addrCtrl, {31'b0, vecOp[idx]});
		readReg(addrStatus, data);                    // still in flight
		checkReg(addrStatus, data, expectStatus(prevFlags, 1'b0, 1'b1));
		waitDone(seen);
		if (seen) begin
			readReg(addrResult, data);
			checkResult(data, vecRes[idx]);
			readReg(addrStatus, data);
			checkFlags(data[flagUnderflow:flagZero], vecFlags[idx]);
			checkReg(addrStatus, data, expectStatus(vecFlags[idx], 1'b0, 1'b0));
		end
		finishTest($sformatf("vector %0d %s %h %h", idx, vecOp[idx].name(), vecA[idx],
		                     vecB[idx]), errorsBefore);
	endtask

	task automatic testBusyWrite();
		int          errorsBefore;
		logic [31:0] data;
		logic        seen;
		errorsBefore = errorCount;
		writeReg(addrOpA, 32'h4040_0000);             // 3.0
		writeReg(addrOpB, 32'h3f80_0000);             // 1.0
		writeReg(addrCtrl, {31'b0, opAdd});
		writeReg(addrCtrl, {31'b0, opSub});           // lands while busy
		waitDone(seen);
		if (seen) begin
			readReg(addrResult, data);
			checkResult(data, 32'h4080_0000);         // 4.0 from the add
			readReg(addrStatus, data);
			checkReg(addrStatus, data, expectStatus(3'b000, 1'b0, 1'b0));
		end
		finishTest("control write while busy", errorsBefore);
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence and watchdog
	//////////////////////////////////////////////////////////////////////

	initial begin
		wbCyc  = 1'b0;
		wbStb  = 1'b0;
		wbWe   = 1'b0;
		wbAdr  = addrOpA;
		wbDatW = '0;
		loadVectors();
		if (errorCount == 0) begin
			wait (rstN);
			@(posedge clk);
			#1;
			testReadback();
			for (int i = 0; i < vecA.size(); i++) begin
				runVector(i);
			end
			testBusyWrite();
		end
		$display("summary: %0d tests, %0d passed, %0d failed, %0d errors, %0d assertion failures",
		         testCount, passCount, failCount, errorCount, UUT.uAssert.assertErrors);
		if (failCount == 0 && errorCount == 0 && UUT.uAssert.assertErrors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	initial begin
		wait (vectorsLoaded);
		#(vecA.size() * nsPerVector + resetNs);
		$display("watchdog expired at %0t, tests did not complete", $time);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

/* tb/fpAlu_assert.sv */
`timescale 1ns/1ps

module fpAluAssert (
	input logic clk,
	input logic rstN,
	input logic wbAck,
	input logic start,
	input logic resValid,
	input logic busy,
	input logic done
);

	int assertErrors = 0;                             // failed assertions so far

	//////////////////////////////////////////////////////////////////////
	// bus handshake and pipeline timing
	//////////////////////////////////////////////////////////////////////

	property ackSingleCycle;
		@(posedge clk) disable iff (!rstN) wbAck |=> !wbAck;
	endproperty

	property resultTwoAfterStart;
		@(posedge clk) disable iff (!rstN) start |-> ##2 resValid;
	endproperty

	property resultOnlyAfterStart;
		@(posedge clk) disable iff (!rstN) resValid |-> $past(start, 2);
	endproperty

	property busyDoneExclusive;
		@(posedge clk) disable iff (!rstN) !(busy && done);
	endproperty

	assert property (ackSingleCycle) else begin
		$error("wbAck stayed high for a second cycle");
		assertErrors++;
	end

	assert property (resultTwoAfterStart) else begin
		$error("resValid missing 2 cycles after start");
		assertErrors++;
	end

	assert property (resultOnlyAfterStart) else begin
		$error("resValid without start 2 cycles before");
		assertErrors++;
	end

	assert property (busyDoneExclusive) else begin
		$error("busy and done high together");
		assertErrors++;
	end

endmodule

/* tb/fpClockGen.sv */
`timescale 1ns/1ps

module fpClockGen (
	output logic clk,
	output logic rstN
);
	localparam int periodNs    = 10;
	localparam int resetCycles = 5;

	initial begin
		clk = 1'b0;
		forever #(periodNs / 2) clk = ~clk;
	end

	// release just after an edge, like every other input
	initial begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		#1 rstN = 1'b1;
	end

endmodule

/* tb/fpTestdata.txt */
# columns, all hex: opcode (0 add, 1 sub), operand A, operand B, expected result, expected flags
# flags: bit 0 zero, bit 1 overflow, bit 2 underflow
0 3f800000 3f800000 40000000 0
0 3fc00000 3fc00000 40400000 0
0 3f800000 40000000 40400000 0
0 3fe00000 3f000000 40100000 0
0 bf800000 c0000000 c0400000 0
1 40400000 3f800000 40000000 0
1 3f800000 40000000 bf800000 0
1 bf800000 c0400000 40000000 0
0 3f800001 3f800000 40000000 0
0 3f800000 34000000 3f800001 0
0 3f800000 33800000 3f800000 0
0 3f800000 30800000 3f800000 0
1 3f800000 3f400000 3e800000 0
1 3f802000 3f800000 3a800000 0
1 3f800001 3f800000 34000000 0
1 3f800000 3f800003 b4c00000 0
0 3f800000 bf800000 00000000 1
1 40200000 40200000 00000000 1
0 80000000 80000000 00000000 1
0 00400000 00000000 00000000 1
0 3fc00000 00000001 3fc00000 0
1 00000000 40000000 c0000000 0
0 7f000000 7f000000 7f800000 2
0 7f7fffff 7f7fffff 7f800000 2
0 ff000000 ff000000 ff800000 2
1 00800001 00800000 00000000 4
1 00800000 00800001 80000000 4
1 00c00000 00800000 00000000 4
1 01000000 00800000 00800000 0
